// File: sim.f
+incdir+source
source/board_io_pkg.sv
source/tick_timer.sv
source/switch_debouncer.sv
source/io_register_block.sv
source/seven_segment_decoder.sv
source/board_io_top.sv
tb/board_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the board I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module board_io_tb -Mdir "$BUILD_DIR" -o board_io_sim -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/board_io_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb/board_io_tb.sv
`timescale 1ns/1ps
`include "board_io_consts.svh"

module board_io_tb import board_io_pkg::*; ();

    localparam int SETTLE_BOUND = (`BIO_SETTLE_COUNT + 1) * `BIO_SAMPLE_DIV + 2;
    localparam int RSP_TIMEOUT = 8;
    localparam logic [31:0] BASE = `BIO_BASE;
    localparam logic [31:0] OUTSIDE = `BIO_BASE ^ 32'h2000_0000;    // other top nibble
    // active low segments g down to a
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_INPUTS, OP_GLITCH, OP_RATE, OP_OUTSIDE
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] ofs;
        logic [31:0] data;       // raw inputs as {key, sw} for input ops
        logic [31:0] expected;
    } entry_t;

    logic        clk;
    logic        reset;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    logic [9:0]  sw;
    logic [3:0]  key;
    led_out_t    leds;
    hex_digits_t hex;
    logic        step_en;
    entry_t      table_q [$];
    logic [17:0] red_model;
    logic [8:0]  green_model;
    logic [3:0]  nibble_model;

    board_io_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t want, input string what);
        if (got !== want)
            stop_run($sformatf("** Error at %0t: %s got %h/%b, expected %h/%b", $time,
                               what, got.rdata, got.valid, want.rdata, want.valid));
    endtask

    task automatic check_leds(input led_out_t got, input led_out_t want, input string what);
        if (got !== want)
            stop_run($sformatf("** Error at %0t: %s leds %h, expected %h", $time, what, got, want));
    endtask

    task automatic check_hex(input hex_digits_t got, input hex_digits_t want, input string what);
        if (got !== want)
            stop_run($sformatf("** Error at %0t: %s hex %h, expected %h", $time, what, got, want));
    endtask

    task automatic check_count(input int got, input int want, input string what);
        if (got != want)
            stop_run($sformatf("** Error at %0t: %s is %0d, expected %0d", $time, what, got, want));
    endtask

    function automatic hex_digits_t expected_hex(input logic [17:0] red, input logic [3:0] nib);
        hex_digits_t h;
        for (int i = 0; i < 4; i++)
            h[i] = SEG_TABLE[red[4*i +: 4]];
        h[4] = SEG_TABLE[{2'b00, red[17:16]}];
        h[5] = SEG_TABLE[nib];
        return h;
    endfunction

    task automatic check_outputs(input string what);
        check_leds(leds, led_out_t'({red_model, green_model}), what);
        check_hex(hex, expected_hex(red_model, nibble_model), what);
    endtask

    task automatic add_entry(input op_e op, input logic [31:0] ofs,
                             input logic [31:0] data, input logic [31:0] expected);
        entry_t e;
        e.op       = op;
        e.ofs      = ofs;
        e.data     = data;
        e.expected = expected;
        table_q.push_back(e);
    endtask

    // enters and leaves on a falling edge
    task automatic do_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic write, output bus_rsp_t rsp, output int lat);
        bus_req = '{addr: addr, wdata: wdata, write: write, valid: 1'b1};
        lat = 1;
        @(negedge clk);
        bus_req.valid = 1'b0;
        while (!bus_rsp.valid && lat < RSP_TIMEOUT) begin
            @(negedge clk);
            lat++;
        end
        rsp = bus_rsp;
    endtask

    task automatic reg_access(input logic [31:0] ofs, input logic [31:0] wdata,
                              input logic write, output bus_rsp_t rsp);
        int lat;
        do_access(BASE + ofs, wdata, write, rsp, lat);
        if (!rsp.valid)
            stop_run("timeout: no bus response to an access inside the block");
        check_count(lat, 1, "response latency");
        nibble_model = BASE[31:28];
    endtask

    // want is {buttons, switches}
    // hold makes every read on the way match
    task automatic read_inputs(input logic [13:0] want, input logic hold, input int limit);
        bus_rsp_t r_sw;
        bus_rsp_t r_key;
        bus_rsp_t want_sw;
        bus_rsp_t want_key;
        int       elapsed;
        want_sw  = '{rdata: {22'b0, want[9:0]}, valid: 1'b1};
        want_key = '{rdata: {28'b0, want[13:10]}, valid: 1'b1};
        elapsed  = 0;
        do begin
            reg_access(`BIO_OFS_SW, '0, 1'b0, r_sw);
            reg_access(`BIO_OFS_KEY, '0, 1'b0, r_key);
            elapsed += 2;
            if (hold) begin
                check_rsp(r_sw, want_sw, "switch read during glitch");
                check_rsp(r_key, want_key, "key read during glitch");
            end
        end while ((hold || r_sw !== want_sw || r_key !== want_key) && elapsed < limit);
        check_rsp(r_sw, want_sw, "switch read-back");
        check_rsp(r_key, want_key, "key read-back");
    endtask

    task automatic measure_step(input int period);
        int gap;
        int n;
        n = 0;
        while (!step_en && n < 2 * period + 4) begin
            @(negedge clk);
            n++;
        end
        if (!step_en)
            stop_run("timeout: no step enable pulse after the rate change");
        repeat (2) begin
            gap = 0;
            do begin
                @(negedge clk);
                gap++;
            end while (!step_en && gap < 2 * period + 4);
            check_count(gap, period, "step enable interval");
        end
    endtask

    initial begin
        entry_t      e;
        bus_rsp_t    r;
        int          lat;
        logic [31:0] d;
        logic [31:0] red_last;
        logic [13:0] held;

        void'($urandom(32'hb2b01e08));
        reset        = 1'b1;
        bus_req      = '0;
        sw           = '0;
        key          = 4'hf;    // released
        red_model    = '0;
        green_model  = '0;
        nibble_model = '0;

        d = $urandom();
        add_entry(OP_WRITE, `BIO_OFS_RED, d, {14'b0, d[17:0]});
        add_entry(OP_READ, `BIO_OFS_RED, '0, {14'b0, d[17:0]});
        d = $urandom();
        add_entry(OP_WRITE, `BIO_OFS_GREEN, d, {23'b0, d[8:0]});
        add_entry(OP_READ, `BIO_OFS_GREEN, '0, {23'b0, d[8:0]});
        d = $urandom();
        red_last = {14'b0, d[17:0]};
        add_entry(OP_WRITE, `BIO_OFS_RED, d, red_last);
        add_entry(OP_READ, `BIO_OFS_RED, '0, red_last);
        add_entry(OP_READ, 32'h2, '0, '0);    // unaligned offset reads zero
        add_entry(OP_READ, 32'h7, '0, '0);
        add_entry(OP_WRITE, `BIO_OFS_SW, $urandom(), '0);
        add_entry(OP_READ, `BIO_OFS_SW, '0, '0);
        add_entry(OP_INPUTS, '0, {4'b1010, 10'h2a4}, {4'b0101, 10'h2a4});
        add_entry(OP_GLITCH, '0, {4'b0101, 10'h15b}, '0);
        add_entry(OP_RATE, '0, {4'hf, 10'h001}, `BIO_STEP_DIV_LO);
        add_entry(OP_RATE, '0, {4'hf, 10'h002}, `BIO_STEP_DIV_MID);
        add_entry(OP_RATE, '0, {4'hf, 10'h000}, 1);
        add_entry(OP_OUTSIDE, `BIO_OFS_RED, $urandom(), '0);
        add_entry(OP_READ, `BIO_OFS_RED, '0, red_last);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_outputs("after reset");
        check_count(int'(bus_rsp.valid), 0, "response strobe after reset");
        repeat (10) begin
            check_count(int'(step_en), 1, "step_en after reset");
            @(negedge clk);
        end

        foreach (table_q[i]) begin
            e = table_q[i];
            case (e.op)
                OP_WRITE: begin
                    reg_access(e.ofs, e.data, 1'b1, r);
                    if (e.ofs == `BIO_OFS_RED)
                        red_model = e.expected[17:0];
                    else if (e.ofs == `BIO_OFS_GREEN)
                        green_model = e.expected[8:0];
                    check_outputs("after write");
                end
                OP_READ: begin
                    reg_access(e.ofs, '0, 1'b0, r);
                    check_rsp(r, '{rdata: e.expected, valid: 1'b1}, "register read");
                    check_outputs("after read");
                end
                OP_INPUTS: begin
                    {key, sw} = e.data[13:0];
                    read_inputs(e.expected[13:0], 1'b0, SETTLE_BOUND);
                end
                OP_GLITCH: begin
                    held = {key, sw};
                    {key, sw} = e.data[13:0];
                    @(negedge clk);
                    {key, sw} = held;    // one clock only
                    read_inputs({~held[13:10], held[9:0]}, 1'b1, 2 * SETTLE_BOUND);
                end
                OP_RATE: begin
                    {key, sw} = e.data[13:0];
                    read_inputs({~key, sw}, 1'b0, SETTLE_BOUND);
                    measure_step(int'(e.expected));
                end
                OP_OUTSIDE: begin
                    do_access(OUTSIDE + e.ofs, e.data, 1'b1, r, lat);
                    if (r.valid)
                        stop_run("response strobe seen for a write outside the block");
                    check_outputs("after write outside the block");
                end
                default: stop_run("unknown operation in the stimulus table");
            endcase
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: source/board_io_top.sv
`timescale 1ns/1ps

module board_io_top import board_io_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  bus_req_t    bus_req,
    output bus_rsp_t    bus_rsp,

    input  logic [9:0]  sw,
    input  logic [3:0]  key,

    output led_out_t    leds,
    output hex_digits_t hex,
    output logic        step_en
);

    logic       sample_tick;
    board_in_t  raw_in;
    board_in_t  clean_in;
    logic [3:0] addr_nibble;
    logic [3:0] digit_val [6];

    assign raw_in = '{switches: sw, buttons: ~key};    // keys are active low

    tick_timer timer0 (
        .clk         ( clk                     ),
        .reset       ( reset                   ),
        .rate_sel    ( clean_in.switches[1:0]  ),
        .sample_tick ( sample_tick             ),
        .step_en     ( step_en                 )
    );

    switch_debouncer debouncer0 (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .sample_tick ( sample_tick ),
        .raw         ( raw_in      ),
        .clean       ( clean_in    )
    );

    io_register_block regs0 (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .req         ( bus_req     ),
        .inputs      ( clean_in    ),
        .rsp         ( bus_rsp     ),
        .leds        ( leds        ),
        .addr_nibble ( addr_nibble )
    );

    assign digit_val[5] = addr_nibble;
    assign digit_val[4] = {2'b00, leds.red.digits.hi};
    assign digit_val[3] = leds.red.digits.d3;
    assign digit_val[2] = leds.red.digits.d2;
    assign digit_val[1] = leds.red.digits.d1;
    assign digit_val[0] = leds.red.digits.d0;

    for (genvar g = 0; g < 6; g++) begin : g_digit
        seven_segment_decoder digit (
            .digit ( digit_val[g] ),
            .seg   ( hex[g]       )
        );
    end

endmodule

// File: source/seven_segment_decoder.sv
`timescale 1ns/1ps

module seven_segment_decoder (
    input  logic [3:0] digit,
    output logic [6:0] seg
);

    // segments g..a, low lights the segment
    always_comb begin
        case (digit)
            4'h0: seg = 7'b100_0000;
            4'h1: seg = 7'b111_1001;
            4'h2: seg = 7'b010_0100;
            4'h3: seg = 7'b011_0000;
            4'h4: seg = 7'b001_1001;
            4'h5: seg = 7'b001_0010;
            4'h6: seg = 7'b000_0010;
            4'h7: seg = 7'b111_1000;
            4'h8: seg = 7'b000_0000;
            4'h9: seg = 7'b001_0000;
            4'ha: seg = 7'b000_1000;
            4'hb: seg = 7'b000_0011;    // lower case b
            4'hc: seg = 7'b100_0110;
            4'hd: seg = 7'b010_0001;    // lower case d
            4'he: seg = 7'b000_0110;
            4'hf: seg = 7'b000_1110;
            default: seg = 7'b111_1111;
        endcase
    end

endmodule

// File: source/io_register_block.sv
`timescale 1ns/1ps
`include "board_io_consts.svh"

module io_register_block import board_io_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  bus_req_t   req,
    input  board_in_t  inputs,
    output bus_rsp_t   rsp,
    output led_out_t   leds,
    output logic [3:0] addr_nibble
);

    localparam logic [31:0] BASE      = `BIO_BASE;
    localparam logic [31:0] OFS_RED   = `BIO_OFS_RED;
    localparam logic [31:0] OFS_GREEN = `BIO_OFS_GREEN;
    localparam logic [31:0] OFS_SW    = `BIO_OFS_SW;
    localparam logic [31:0] OFS_KEY   = `BIO_OFS_KEY;

    logic        hit;
    logic        aligned;
    logic [1:0]  word;
    logic [31:0] rdata_next;
    logic [31:0] rsp_rdata;
    logic        rsp_valid;
    led_out_t    led_q;

    assign hit     = req.valid && (req.addr[31:4] == BASE[31:4]);
    assign aligned = (req.addr[1:0] == 2'b00);
    assign word    = req.addr[3:2];

    always_comb begin
        rdata_next = '0;    // unaligned reads give zero
        if (aligned) begin
            case (word)
                OFS_RED[3:2]:   rdata_next = {14'b0, led_q.red.raw};
                OFS_GREEN[3:2]: rdata_next = {23'b0, led_q.green};
                OFS_SW[3:2]:    rdata_next = {22'b0, inputs.switches};
                OFS_KEY[3:2]:   rdata_next = {28'b0, inputs.buttons};
                default:        rdata_next = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            led_q       <= '0;
            rsp_valid   <= 1'b0;
            addr_nibble <= 4'h0;
        end else begin
            rsp_valid <= hit;    // writes are acked too
            if (hit)
                addr_nibble <= req.addr[31:28];
            if (hit && req.write && aligned) begin
                if (word == OFS_RED[3:2])
                    led_q.red.raw <= req.wdata[17:0];
                else if (word == OFS_GREEN[3:2])
                    led_q.green <= req.wdata[8:0];
            end
        end
    end

    // write ack returns the old contents
    always_ff @(posedge clk) begin
        if (hit)
            rsp_rdata <= rdata_next;
    end

    assign rsp  = '{rdata: rsp_rdata, valid: rsp_valid};
    assign leds = led_q;

    a_write_known : assert property (@(posedge clk) disable iff (reset)
        req.valid |-> !$isunknown(req.write));

endmodule

// File: source/switch_debouncer.sv
`timescale 1ns/1ps
`include "board_io_consts.svh"

module switch_debouncer import board_io_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      sample_tick,
    input  board_in_t raw,
    output board_in_t clean
);

    localparam int N     = $bits(board_in_t);
    localparam int CNT_W = $clog2(`BIO_SETTLE_COUNT + 1);

    typedef enum logic [1:0] {
        ST_STABLE   = 2'b01,
        ST_SETTLING = 2'b10
    } db_state_t;

    logic [N-1:0]     raw_bits;
    logic [N-1:0]     sync1;
    logic [N-1:0]     sync2;
    logic [N-1:0]     clean_bits;
    db_state_t        state [N];
    logic [CNT_W-1:0] settle_cnt [N];

    assign raw_bits = raw;
    assign clean    = board_in_t'(clean_bits);

    always_ff @(posedge clk) begin
        if (reset) begin
            sync1      <= '0;
            sync2      <= '0;
            clean_bits <= '0;
            for (int i = 0; i < N; i++) begin
                state[i]      <= ST_STABLE;
                settle_cnt[i] <= '0;
            end
        end else begin
            sync1 <= raw_bits;
            sync2 <= sync1;
            if (sample_tick) begin
                for (int i = 0; i < N; i++) begin
                    case (state[i])
                        ST_STABLE: begin
                            if (sync2[i] != clean_bits[i]) begin
                                state[i]      <= ST_SETTLING;
                                settle_cnt[i] <= CNT_W'(1);
                            end
                        end
                        ST_SETTLING: begin
                            if (sync2[i] == clean_bits[i]) begin
                                state[i]      <= ST_STABLE;    // glitch, drop it
                                settle_cnt[i] <= '0;
                            end else if (settle_cnt[i] == CNT_W'(`BIO_SETTLE_COUNT - 1)) begin
                                clean_bits[i] <= sync2[i];
                                state[i]      <= ST_STABLE;
                                settle_cnt[i] <= '0;
                            end else begin
                                settle_cnt[i] <= settle_cnt[i] + 1'b1;
                            end
                        end
                        default: state[i] <= ST_STABLE;
                    endcase
                end
            end
        end
    end

    for (genvar g = 0; g < N; g++) begin : g_state_chk
        a_state_legal : assert property (@(posedge clk) disable iff (reset)
            state[g] inside {ST_STABLE, ST_SETTLING});
    end

endmodule

// File: source/tick_timer.sv
`timescale 1ns/1ps
`include "board_io_consts.svh"

module tick_timer (
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] rate_sel,
    output logic       sample_tick,
    output logic       step_en
);

    localparam int SAMPLE_W = $clog2(`BIO_SAMPLE_DIV + 1);
    localparam int STEP_MAX = (`BIO_STEP_DIV_LO > `BIO_STEP_DIV_MID) ?
                              `BIO_STEP_DIV_LO : `BIO_STEP_DIV_MID;
    localparam int STEP_W   = $clog2(STEP_MAX + 1);

    logic [SAMPLE_W-1:0] sample_cnt;
    logic [STEP_W-1:0]   step_cnt;
    logic [STEP_W-1:0]   period_m1;
    logic [1:0]          rate_sel_q;

    assign sample_tick = (sample_cnt == SAMPLE_W'(`BIO_SAMPLE_DIV - 1));

    always_comb begin
        if (rate_sel[0])
            period_m1 = STEP_W'(`BIO_STEP_DIV_LO - 1);
        else if (rate_sel[1])
            period_m1 = STEP_W'(`BIO_STEP_DIV_MID - 1);
        else
            period_m1 = '0;    // full speed
    end

    assign step_en = (step_cnt == '0) || (period_m1 == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            sample_cnt <= '0;
            step_cnt   <= '0;
            rate_sel_q <= 2'b00;
        end else begin
            sample_cnt <= sample_tick ? '0 : sample_cnt + 1'b1;
            rate_sel_q <= rate_sel;
            if (rate_sel != rate_sel_q || step_cnt == '0)
                step_cnt <= period_m1;    // restart on rate change
            else
                step_cnt <= step_cnt - 1'b1;
        end
    end

    a_tick_single : assert property (@(posedge clk) disable iff (reset)
        sample_tick |=> !sample_tick);

endmodule

// File: source/board_io_pkg.sv
package board_io_pkg;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        write;
        logic        valid;    // single cycle strobe
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        valid;
    } bus_rsp_t;

    typedef struct packed {
        logic [9:0] switches;
        logic [3:0] buttons;   // active high
    } board_in_t;

    typedef struct packed {
        logic [1:0] hi;
        logic [3:0] d3;
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } red_digits_t;

    // red LED word, also read as display nibbles
    typedef union packed {
        logic [17:0] raw;
        red_digits_t digits;
    } red_leds_u;

    typedef struct packed {
        red_leds_u  red;
        logic [8:0] green;
    } led_out_t;

    typedef logic [5:0][6:0] hex_digits_t;

endpackage

// File: source/board_io_consts.svh
`ifndef BOARD_IO_CONSTS_SVH
`define BOARD_IO_CONSTS_SVH

// bus placement of the I/O block
`define BIO_BASE          32'h1f80_0000
`define BIO_OFS_RED       32'h0000_0000
`define BIO_OFS_GREEN     32'h0000_0004
`define BIO_OFS_SW        32'h0000_0008
`define BIO_OFS_KEY       32'h0000_000c

// clocks per debounce sample, small for simulation
`define BIO_SAMPLE_DIV    4

// agreeing samples before a debounced bit flips
`define BIO_SETTLE_COUNT  3

// step enable periods of the two slow rates
`define BIO_STEP_DIV_MID  8
`define BIO_STEP_DIV_LO   32

`endif
